// File: dcache.f
source/dcache_pkg.sv
source/store_decode.sv
source/cache_arrays.sv
source/cache_ctrl.sv
source/load_format.sv
source/dcache_top.sv
testbench/mem_model.sv
testbench/tb_dcache.sv

// File: testbench/tb_dcache.sv
`default_nettype none

module tb_dcache
    import dcache_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_accesses = 365;
    localparam int mem_words    = 1024;

    logic       clk;
    logic       arst_n;
    logic       rvalid, wvalid, uncache;
    addr_t      addr;
    word_t      wdata, rdata;
    mem_op_t    mem_type;
    logic       rready, wready;
    logic [4:0] stall;
    logic       bp_en;

    logic       d_arvalid, d_arready, d_rvalid, d_rready, d_rlast;
    logic       d_awvalid, d_awready, d_wvalid, d_wready, d_wlast, d_bvalid, d_bready;
    addr_t      d_araddr, d_awaddr;
    logic [7:0] d_arlen, d_awlen;
    word_t      d_rdata, d_wdata;
    strb_t      d_wstrb;

    integer  seed;
    string   test_name;
    word_t   exp_rdata;
    logic    load_pending;
    int      refill_count, wb_count, lat;
    addr_t   wb_expect[$];

    word_t   shadow [mem_words];
    tag_t    m_tag   [2][sets];
    logic    m_valid [2][sets];
    logic    m_dirty [2][sets];
    logic    m_lru   [sets];   // way to replace next

    mem_op_t load_ops [5] = '{op_ldw, op_ldb, op_ldh, op_ldbu, op_ldhu};

    dcache_top dut0 (
        .clk (clk), .arst_n (arst_n),
        .rvalid (rvalid), .wvalid (wvalid), .addr (addr), .wdata (wdata),
        .mem_type (mem_type), .uncache (uncache),
        .rdata (rdata), .rready (rready), .wready (wready),
        .d_arvalid (d_arvalid), .d_arready (d_arready), .d_araddr (d_araddr),
        .d_arlen (d_arlen), .d_rvalid (d_rvalid), .d_rready (d_rready),
        .d_rdata (d_rdata), .d_rlast (d_rlast),
        .d_awvalid (d_awvalid), .d_awready (d_awready), .d_awaddr (d_awaddr),
        .d_awlen (d_awlen), .d_wvalid (d_wvalid), .d_wready (d_wready),
        .d_wdata (d_wdata), .d_wstrb (d_wstrb), .d_wlast (d_wlast),
        .d_bvalid (d_bvalid), .d_bready (d_bready)
    );

    mem_model mem0 (
        .clk (clk), .arst_n (arst_n), .stall (stall),
        .d_arvalid (d_arvalid), .d_arready (d_arready), .d_araddr (d_araddr),
        .d_arlen (d_arlen), .d_rvalid (d_rvalid), .d_rready (d_rready),
        .d_rdata (d_rdata), .d_rlast (d_rlast),
        .d_awvalid (d_awvalid), .d_awready (d_awready), .d_awaddr (d_awaddr),
        .d_wvalid (d_wvalid), .d_wready (d_wready),
        .d_wdata (d_wdata), .d_wstrb (d_wstrb), .d_wlast (d_wlast),
        .d_bvalid (d_bvalid), .d_bready (d_bready)
    );

    task automatic fail_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_word(string name, word_t exp, word_t act);
        if (exp !== act) begin
            $display("** Error %s: expected %h actual %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic compare_addr(string name, addr_t exp, addr_t act);
        if (exp !== act) begin
            $display("** Error %s: expected address %h actual %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic compare_count(string name, int exp, int act);
        if (exp != act) begin
            $display("** Error %s: expected %0d actual %0d", name, exp, act);
            fail_run();
        end
    endtask

    // load rules applied to the shadow word
    function automatic word_t expect_load(mem_op_t op, addr_t a);
        word_t       w;
        logic [7:0]  b;
        logic [15:0] h;
        w = shadow[a[11:2]];
        b = w[8*a[1:0] +: 8];
        h = a[1] ? w[31:16] : w[15:0];
        case (op)
            op_ldb:  return {{24{b[7]}}, b};
            op_ldbu: return {24'h0, b};
            op_ldh:  return a[0] ? w : {{16{h[15]}}, h};
            op_ldhu: return a[0] ? w : {16'h0, h};
            default: return w;
        endcase
    endfunction

    task automatic shadow_store(mem_op_t op, addr_t a, word_t d);
        case (op)
            op_stb: shadow[a[11:2]][8*a[1:0] +: 8] = d[7:0];
            op_sth: begin
                if (a[1:0] == 2'd0) shadow[a[11:2]][15:0] = d[15:0];
                else if (a[1:0] == 2'd2) shadow[a[11:2]][31:16] = d[15:0];
                else shadow[a[11:2]] = d;   // misaligned goes out whole
            end
            default: shadow[a[11:2]] = d;
        endcase
    endtask

    // tag and lru tracking to predict writeback addresses
    task automatic track_cached(addr_t a, logic wr);
        tag_t   t;
        index_t s;
        int     w;
        t = a[31:8];
        s = a[7:4];
        w = -1;
        for (int i = 0; i < 2; i++) begin
            if (m_valid[i][s] && m_tag[i][s] == t) w = i;
        end
        if (w < 0) begin
            w = int'(m_lru[s]);
            if (m_valid[w][s] && m_dirty[w][s]) wb_expect.push_back({m_tag[w][s], s, 4'b0000});
            m_tag[w][s]   = t;
            m_valid[w][s] = 1'b1;
            m_dirty[w][s] = 1'b0;
        end
        if (wr) m_dirty[w][s] = 1'b1;
        m_lru[s] = (w == 0);
    endtask

    task automatic run_access(mem_op_t op, addr_t a, word_t d, logic unc, output int latency);
        logic wr;
        int   n;
        wr = (op == op_stw) || (op == op_stb) || (op == op_sth);
        if (wr) shadow_store(op, a, d);
        else exp_rdata = expect_load(op, a);
        if (!unc) track_cached(a, wr);
        @(posedge clk);
        #2;
        load_pending = !wr;
        addr     = a;
        wdata    = d;
        mem_type = op;
        uncache  = unc;
        rvalid   = !wr;
        wvalid   = wr;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(rready || wready));
        latency = n - 1;   // cycles after the capture edge
        @(posedge clk);
        #2;
        rvalid       = 1'b0;
        wvalid       = 1'b0;
        load_pending = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // memory back-pressure
    initial begin
        forever begin
            @(posedge clk);
            #2;
            stall = bp_en ? 5'($random(seed)) : 5'b0;
        end
    end

    // compare process
    always @(negedge clk) begin
        if (arst_n) begin
            if (rready) begin
                if (!load_pending) begin
                    $display("** Error %s: read response without a pending load", test_name);
                    fail_run();
                end else begin
                    compare_word(test_name, exp_rdata, rdata);
                end
            end
            if (wready && load_pending) begin
                $display("** Error %s: a load was answered with a write response", test_name);
                fail_run();
            end
            if (d_awvalid && d_awready && d_awlen == burst_len_line) begin
                wb_count++;
                if (wb_expect.size() == 0) begin
                    $display("** Error %s: writeback of %h was not expected", test_name, d_awaddr);
                    fail_run();
                end else begin
                    compare_addr(test_name, wb_expect.pop_front(), d_awaddr);
                end
            end
            if (d_arvalid && d_arready && d_arlen == burst_len_line) refill_count++;
        end
    end

    initial begin
        #(longint'(num_accesses) * 200 * 20);
        $display("watchdog: the cache stopped responding");
        fail_run();
    end

    initial begin
        int     r0;
        integer r;
        addr_t  a;
        mem_op_t op;
        logic   unc;
        seed         = 32'h28ded041;
        arst_n       = 1'b0;
        rvalid       = 1'b0;
        wvalid       = 1'b0;
        addr         = '0;
        wdata        = '0;
        mem_type     = op_ldw;
        uncache      = 1'b0;
        stall        = '0;
        bp_en        = 1'b0;
        load_pending = 1'b0;
        refill_count = 0;
        wb_count     = 0;
        for (int i = 0; i < mem_words; i++) shadow[i] = ~(32'(i) * 32'd4);
        for (int s = 0; s < sets; s++) begin
            m_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                m_valid[w][s] = 1'b0;
                m_dirty[w][s] = 1'b0;
                m_tag[w][s]   = '0;
            end
        end
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;

        test_name = "cold_loads";
        run_access(op_ldw, 32'h000, '0, 1'b0, lat);
        run_access(op_ldw, 32'h010, '0, 1'b0, lat);
        run_access(op_ldw, 32'h104, '0, 1'b0, lat);
        compare_count("cold_refills", 3, refill_count);
        test_name = "hit_repeat";
        run_access(op_ldw, 32'h004, '0, 1'b0, lat);
        compare_count("hit_latency", 2, lat);
        compare_count("hit_refills", 3, refill_count);

        test_name = "narrow_access";
        for (int b = 0; b < 4; b++) begin
            run_access(op_stb, 32'h340 + b, $random(seed), 1'b0, lat);
            run_access(op_sth, 32'h344 + (b & 2), $random(seed), 1'b0, lat);
            foreach (load_ops[k]) begin
                run_access(load_ops[k], 32'h340 + b, '0, 1'b0, lat);
                run_access(load_ops[k], 32'h344 + b, '0, 1'b0, lat);
            end
        end

        test_name = "lru_evict";
        run_access(op_stw, 32'h050, $random(seed), 1'b0, lat);
        run_access(op_stw, 32'h150, $random(seed), 1'b0, lat);
        run_access(op_ldw, 32'h250, '0, 1'b0, lat);
        run_access(op_ldw, 32'h050, '0, 1'b0, lat);
        run_access(op_ldw, 32'h150, '0, 1'b0, lat);
        compare_count("lru_writebacks", 2, wb_count);

        test_name = "uncached";
        r0 = refill_count;
        run_access(op_stb, 32'h801, 32'h0000_00a5, 1'b1, lat);
        run_access(op_sth, 32'h806, 32'h0000_1234, 1'b1, lat);
        run_access(op_stw, 32'h808, $random(seed), 1'b1, lat);
        run_access(op_ldw, 32'h800, '0, 1'b1, lat);
        run_access(op_ldw, 32'h804, '0, 1'b1, lat);
        run_access(op_ldbu, 32'h801, '0, 1'b1, lat);
        run_access(op_ldh, 32'h806, '0, 1'b1, lat);
        compare_count("uncached_no_refill", r0, refill_count);
        run_access(op_ldw, 32'h800, '0, 1'b0, lat);
        compare_count("cached_after_uncached", r0 + 1, refill_count);

        test_name = "random_mix";
        bp_en = 1'b1;
        for (int i = 0; i < 300; i++) begin
            r   = $random(seed);
            op  = mem_op_t'(r[2:0]);
            unc = (r[5:4] == 2'b00);
            r   = $random(seed);
            // uncached traffic kept apart from cached lines
            a = unc ? (32'hc00 | 32'(r[9:0])) : 32'(r[10:0]);
            if (op == op_ldw || op == op_stw) a[1:0] = 2'b00;
            if (op == op_ldh || op == op_ldhu || op == op_sth) a[0] = 1'b0;
            run_access(op, a, $random(seed), unc, lat);
        end
        bp_en = 1'b0;

        if (wb_expect.size() != 0) begin
            $display("** Error %s: %0d predicted writebacks never happened",
                     test_name, wb_expect.size());
            fail_run();
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: testbench/mem_model.sv
`default_nettype none

module mem_model
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic [4:0] stall,      // arready, rvalid, awready, wready, bvalid
    input  logic       d_arvalid,
    output logic       d_arready,
    input  addr_t      d_araddr,
    input  logic [7:0] d_arlen,
    output logic       d_rvalid,
    input  logic       d_rready,
    output word_t      d_rdata,
    output logic       d_rlast,
    input  logic       d_awvalid,
    output logic       d_awready,
    input  addr_t      d_awaddr,
    input  logic       d_wvalid,
    output logic       d_wready,
    input  word_t      d_wdata,
    input  strb_t      d_wstrb,
    input  logic       d_wlast,
    output logic       d_bvalid,
    input  logic       d_bready
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int depth = 1024;

    word_t      mem [depth];
    logic       rd_busy;
    addr_t      rd_addr;
    logic [7:0] rd_left;   // beats after the current one
    logic [1:0] wr_phase;  // 0 address, 1 data, 2 response
    addr_t      wr_addr;

    assign d_rdata = mem[rd_addr[11:2]];
    assign d_rlast = (rd_left == 8'd0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < depth; i++) mem[i] <= ~(addr_t'(i) << 2);
            rd_busy   <= 1'b0;
            rd_addr   <= '0;
            rd_left   <= '0;
            d_arready <= 1'b0;
            d_rvalid  <= 1'b0;
            wr_phase  <= 2'd0;
            wr_addr   <= '0;
            d_awready <= 1'b0;
            d_wready  <= 1'b0;
            d_bvalid  <= 1'b0;
        end else begin
            // read channel
            if (!rd_busy) begin
                if (d_arvalid && d_arready) begin
                    rd_busy   <= 1'b1;
                    rd_addr   <= d_araddr;
                    rd_left   <= d_arlen;
                    d_arready <= 1'b0;
                end else begin
                    d_arready <= !stall[0];
                end
            end else if (d_rvalid && d_rready) begin
                rd_addr <= rd_addr + 32'd4;
                rd_left <= rd_left - 8'd1;
                if (rd_left == 8'd0) begin
                    rd_busy  <= 1'b0;
                    d_rvalid <= 1'b0;
                end else begin
                    d_rvalid <= !stall[1];
                end
            end else if (!d_rvalid) begin
                d_rvalid <= !stall[1];
            end

            // write channel
            case (wr_phase)
                2'd0: begin
                    if (d_awvalid && d_awready) begin
                        wr_addr   <= d_awaddr;
                        wr_phase  <= 2'd1;
                        d_awready <= 1'b0;
                    end else begin
                        d_awready <= !stall[2];
                    end
                end
                2'd1: begin
                    if (d_wvalid && d_wready) begin
                        for (int b = 0; b < 4; b++) begin
                            if (d_wstrb[b]) mem[wr_addr[11:2]][8*b +: 8] <= d_wdata[8*b +: 8];
                        end
                        wr_addr <= wr_addr + 32'd4;
                        if (d_wlast) begin
                            wr_phase <= 2'd2;
                            d_wready <= 1'b0;
                        end else begin
                            d_wready <= !stall[3];
                        end
                    end else begin
                        d_wready <= !stall[3];
                    end
                end
                default: begin
                    if (d_bvalid && d_bready) begin
                        d_bvalid <= 1'b0;
                        wr_phase <= 2'd0;
                    end else if (!d_bvalid) begin
                        d_bvalid <= !stall[4];
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/dcache_top.sv
`default_nettype none

module dcache_top
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       rvalid,
    input  logic       wvalid,
    input  addr_t      addr,
    input  word_t      wdata,
    input  mem_op_t    mem_type,
    input  logic       uncache,
    output word_t      rdata,
    output logic       rready,
    output logic       wready,
    output logic       d_arvalid,
    input  logic       d_arready,
    output addr_t      d_araddr,
    output logic [7:0] d_arlen,
    input  logic       d_rvalid,
    output logic       d_rready,
    input  word_t      d_rdata,
    input  logic       d_rlast,
    output logic       d_awvalid,
    input  logic       d_awready,
    output addr_t      d_awaddr,
    output logic [7:0] d_awlen,
    output logic       d_wvalid,
    input  logic       d_wready,
    output word_t      d_wdata,
    output strb_t      d_wstrb,
    output logic       d_wlast,
    input  logic       d_bvalid,
    output logic       d_bready
);

    cpu_req_t        req_in, req;
    store_t          store;
    word_t           load_word;
    index_t          rd_index, wr_index;
    logic [ways-1:0] tag_we, data_we, rd_valid, rd_dirty;
    tag_t            wr_tag, rd_tag0, rd_tag1;
    logic            wr_dirty, lru_we, lru_used_way, lru_way;
    line_t           wr_line, rd_line0, rd_line1;

    assign req_in = {addr, wdata, mem_type, wvalid, uncache};

    store_decode u_decode (
        .req   (req),
        .store (store)
    );

    cache_arrays u_arrays (
        .clk          (clk),
        .arst_n       (arst_n),
        .rd_index     (rd_index),
        .wr_index     (wr_index),
        .tag_we       (tag_we),
        .wr_tag       (wr_tag),
        .wr_dirty     (wr_dirty),
        .data_we      (data_we),
        .wr_line      (wr_line),
        .lru_we       (lru_we),
        .lru_used_way (lru_used_way),
        .rd_tag0      (rd_tag0),
        .rd_tag1      (rd_tag1),
        .rd_valid     (rd_valid),
        .rd_dirty     (rd_dirty),
        .rd_line0     (rd_line0),
        .rd_line1     (rd_line1),
        .lru_way      (lru_way)
    );

    cache_ctrl u_ctrl (
        .clk (clk), .arst_n (arst_n),
        .rvalid (rvalid), .wvalid (wvalid),
        .req_in (req_in), .req (req), .store (store),
        .rready (rready), .wready (wready), .load_word (load_word),
        .rd_index (rd_index), .wr_index (wr_index),
        .tag_we (tag_we), .wr_tag (wr_tag), .wr_dirty (wr_dirty),
        .data_we (data_we), .wr_line (wr_line),
        .lru_we (lru_we), .lru_used_way (lru_used_way),
        .rd_tag0 (rd_tag0), .rd_tag1 (rd_tag1),
        .rd_valid (rd_valid), .rd_dirty (rd_dirty),
        .rd_line0 (rd_line0), .rd_line1 (rd_line1), .lru_way (lru_way),
        .d_arvalid (d_arvalid), .d_arready (d_arready),
        .d_araddr (d_araddr), .d_arlen (d_arlen),
        .d_rvalid (d_rvalid), .d_rready (d_rready),
        .d_rdata (d_rdata), .d_rlast (d_rlast),
        .d_awvalid (d_awvalid), .d_awready (d_awready),
        .d_awaddr (d_awaddr), .d_awlen (d_awlen),
        .d_wvalid (d_wvalid), .d_wready (d_wready),
        .d_wdata (d_wdata), .d_wstrb (d_wstrb), .d_wlast (d_wlast),
        .d_bvalid (d_bvalid), .d_bready (d_bready)
    );

    load_format u_format (
        .op       (req.op),
        .byte_sel (req.addr[1:0]),
        .word     (load_word),
        .rdata    (rdata)
    );

endmodule

`default_nettype wire

// File: source/load_format.sv
`default_nettype none

module load_format
    import dcache_pkg::*;
(
    input  mem_op_t    op,
    input  logic [1:0] byte_sel,
    input  word_t      word,
    output word_t      rdata
);

    logic [7:0]  byte_val;
    logic [15:0] half_val;

    assign byte_val = word[8*byte_sel +: 8];
    assign half_val = byte_sel[1] ? word[31:16] : word[15:0];

    always_comb begin
        rdata = word;
        case (op)
            op_ldb:  rdata = {{24{byte_val[7]}}, byte_val};
            op_ldbu: rdata = {24'h0, byte_val};
            op_ldh: begin
                if (!byte_sel[0]) rdata = {{16{half_val[15]}}, half_val};
            end
            op_ldhu: begin
                // odd half-word offsets fall through unchanged
                if (!byte_sel[0]) rdata = {16'h0, half_val};
            end
            default: rdata = word;
        endcase
    end

endmodule

`default_nettype wire

// File: source/cache_ctrl.sv
`default_nettype none

module cache_ctrl
    import dcache_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            rvalid,
    input  logic            wvalid,
    input  cpu_req_t        req_in,
    output cpu_req_t        req,
    input  store_t          store,
    output logic            rready,
    output logic            wready,
    output word_t           load_word,
    output index_t          rd_index,
    output index_t          wr_index,
    output logic [ways-1:0] tag_we,
    output tag_t            wr_tag,
    output logic            wr_dirty,
    output logic [ways-1:0] data_we,
    output line_t           wr_line,
    output logic            lru_we,
    output logic            lru_used_way,
    input  tag_t            rd_tag0,
    input  tag_t            rd_tag1,
    input  logic [ways-1:0] rd_valid,
    input  logic [ways-1:0] rd_dirty,
    input  line_t           rd_line0,
    input  line_t           rd_line1,
    input  logic            lru_way,
    output logic            d_arvalid,
    input  logic            d_arready,
    output addr_t           d_araddr,
    output logic [7:0]      d_arlen,
    input  logic            d_rvalid,
    output logic            d_rready,
    input  word_t           d_rdata,
    input  logic            d_rlast,
    output logic            d_awvalid,
    input  logic            d_awready,
    output addr_t           d_awaddr,
    output logic [7:0]      d_awlen,
    output logic            d_wvalid,
    input  logic            d_wready,
    output word_t           d_wdata,
    output strb_t           d_wstrb,
    output logic            d_wlast,
    input  logic            d_bvalid,
    output logic            d_bready
);

    typedef enum logic [3:0] {
        st_idle, st_lookup, st_wb_addr, st_wb_data, st_wb_resp,
        st_rf_addr, st_rf_data, st_unc_read, st_unc_write, st_done
    } state_t;

    state_t  state, state_nx;
    offset_t cnt;      // beat count, or phase for uncached
    logic    cnt_inc;
    logic    way;      // victim way of a miss
    line_t   fill_line, next_fill, hit_line, vic_line, base_line;
    word_t   rword;
    tag_t    req_tag, vic_tag;
    index_t  req_index;
    offset_t req_off;
    logic    hit0, hit1, hit;

    // write store data into one word of a line
    function automatic line_t merge_line(line_t line, offset_t off, store_t st);
        line_t m;
        m = line;
        for (int b = 0; b < 4; b++) begin
            if (st.strb[b]) m[32*off + 8*b +: 8] = st.data[8*b +: 8];
        end
        return m;
    endfunction

    assign req_tag   = req.addr[31:8];
    assign req_index = req.addr[7:4];
    assign req_off   = req.addr[3:2];

    assign hit0 = rd_valid[0] && (rd_tag0 == req_tag);
    assign hit1 = rd_valid[1] && (rd_tag1 == req_tag);
    assign hit  = hit0 | hit1;

    assign hit_line = hit1 ? rd_line1 : rd_line0;
    assign vic_line = way ? rd_line1 : rd_line0;
    assign vic_tag  = way ? rd_tag1 : rd_tag0;

    always_comb begin
        next_fill = fill_line;
        next_fill[32*cnt +: 32] = d_rdata;
    end

    // array side, read early in idle so lookup can compare
    assign rd_index     = (state == st_idle) ? index_t'(req_in.addr[7:4]) : req_index;
    assign wr_index     = req_index;
    assign wr_tag       = req_tag;
    assign wr_dirty     = req.is_write;
    assign base_line    = (state == st_rf_data) ? next_fill : hit_line;
    assign wr_line      = req.is_write ? merge_line(base_line, req_off, store) : base_line;
    assign lru_used_way = (state == st_lookup) ? hit1 : way;

    // memory side
    assign d_araddr = req.uncache ? req.addr : {req_tag, req_index, 4'b0000};
    assign d_awaddr = req.uncache ? req.addr : {vic_tag, req_index, 4'b0000};
    assign d_arlen  = req.uncache ? burst_len_single : burst_len_line;
    assign d_awlen  = req.uncache ? burst_len_single : burst_len_line;
    assign d_wdata  = req.uncache ? store.data : vic_line[32*cnt +: 32];
    assign d_wstrb  = req.uncache ? store.strb : 4'b1111;

    assign rready    = (state == st_done) && !req.is_write;
    assign wready    = (state == st_done) && req.is_write;
    assign load_word = rword;

    always_comb begin
        state_nx  = state;
        cnt_inc   = 1'b0;
        tag_we    = '0;
        data_we   = '0;
        lru_we    = 1'b0;
        d_arvalid = 1'b0;
        d_rready  = 1'b0;
        d_awvalid = 1'b0;
        d_wvalid  = 1'b0;
        d_wlast   = 1'b0;
        d_bready  = 1'b0;
        case (state)
            st_idle: begin
                if (rvalid || wvalid) begin
                    if (req_in.uncache) state_nx = wvalid ? st_unc_write : st_unc_read;
                    else state_nx = st_lookup;
                end
            end
            st_lookup: begin
                if (hit) begin
                    lru_we   = 1'b1;
                    tag_we   = req.is_write ? {hit1, hit0} : 2'b00; // sets dirty
                    data_we  = req.is_write ? {hit1, hit0} : 2'b00;
                    state_nx = st_done;
                end else if (rd_valid[lru_way] && rd_dirty[lru_way]) begin
                    state_nx = st_wb_addr;
                end else begin
                    state_nx = st_rf_addr;
                end
            end
            st_wb_addr: begin
                d_awvalid = 1'b1;
                if (d_awready) state_nx = st_wb_data;
            end
            st_wb_data: begin
                d_wvalid = 1'b1;
                d_wlast  = (cnt == offset_t'(words_per_line - 1));
                if (d_wready) begin
                    cnt_inc = 1'b1;
                    if (d_wlast) state_nx = st_wb_resp;
                end
            end
            st_wb_resp: begin
                d_bready = 1'b1;
                if (d_bvalid) state_nx = st_rf_addr;
            end
            st_rf_addr: begin
                d_arvalid = 1'b1;
                if (d_arready) state_nx = st_rf_data;
            end
            st_rf_data: begin
                d_rready = 1'b1;
                if (d_rvalid) begin
                    cnt_inc = 1'b1;
                    if (d_rlast) begin
                        tag_we[way]  = 1'b1;
                        data_we[way] = 1'b1;
                        lru_we       = 1'b1;
                        state_nx     = st_done;
                    end
                end
            end
            st_unc_read: begin
                d_arvalid = (cnt == 2'd0);
                d_rready  = (cnt == 2'd1);
                if (d_arvalid && d_arready) cnt_inc = 1'b1;
                if (d_rready && d_rvalid) state_nx = st_done;
            end
            st_unc_write: begin
                d_awvalid = (cnt == 2'd0);
                d_wvalid  = (cnt == 2'd1);
                d_wlast   = (cnt == 2'd1); // single beat
                d_bready  = (cnt == 2'd2);
                if ((d_awvalid && d_awready) || (d_wvalid && d_wready)) cnt_inc = 1'b1;
                if (d_bready && d_bvalid) state_nx = st_done;
            end
            st_done: state_nx = st_idle;
            default: state_nx = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            cnt   <= '0;
            way   <= 1'b0;
        end else begin
            state <= state_nx;
            if (state == st_idle) cnt <= '0;
            else if (cnt_inc) cnt <= cnt + 2'd1;
            if (state == st_lookup) way <= lru_way;
        end
    end

    // request, refill buffer and returned word
    always_ff @(posedge clk) begin
        if (state == st_idle && (rvalid || wvalid)) req <= req_in;
        if (state == st_lookup) rword <= hit_line[32*req_off +: 32];
        if (state == st_rf_data && d_rvalid) begin
            fill_line <= next_fill;
            if (d_rlast) rword <= next_fill[32*req_off +: 32];
        end
        if (state == st_unc_read && d_rready && d_rvalid) rword <= d_rdata;
    end

endmodule

`default_nettype wire

// File: source/cache_arrays.sv
`default_nettype none

module cache_arrays
    import dcache_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  index_t          rd_index,
    input  index_t          wr_index,
    input  logic [ways-1:0] tag_we,
    input  tag_t            wr_tag,
    input  logic            wr_dirty,
    input  logic [ways-1:0] data_we,
    input  line_t           wr_line,
    input  logic            lru_we,
    input  logic            lru_used_way,
    output tag_t            rd_tag0,
    output tag_t            rd_tag1,
    output logic [ways-1:0] rd_valid,
    output logic [ways-1:0] rd_dirty,
    output line_t           rd_line0,
    output line_t           rd_line1,
    output logic            lru_way
);

    tag_t  tag_mem   [ways][sets];
    logic  dirty_mem [ways][sets];
    line_t data_mem  [ways][sets];

    logic [ways-1:0][sets-1:0] valid_q;
    logic [sets-1:0]           lru_q;   // way to replace next

    // valid and lru bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q  <= '0;
            lru_q    <= '0;
            rd_valid <= '0;
            lru_way  <= 1'b0;
        end else begin
            for (int w = 0; w < ways; w++) begin
                if (tag_we[w]) valid_q[w][wr_index] <= 1'b1;
                rd_valid[w] <= valid_q[w][rd_index];
            end
            if (lru_we) lru_q[wr_index] <= ~lru_used_way; // point at the other way
            lru_way <= lru_q[rd_index];
        end
    end

    // tag, dirty and line storage
    always_ff @(posedge clk) begin
        for (int w = 0; w < ways; w++) begin
            if (tag_we[w]) begin
                tag_mem[w][wr_index]   <= wr_tag;
                dirty_mem[w][wr_index] <= wr_dirty;
            end
            if (data_we[w]) data_mem[w][wr_index] <= wr_line;
            rd_dirty[w] <= dirty_mem[w][rd_index];
        end
        rd_tag0  <= tag_mem[0][rd_index];
        rd_tag1  <= tag_mem[1][rd_index];
        rd_line0 <= data_mem[0][rd_index];
        rd_line1 <= data_mem[1][rd_index];
    end

endmodule

`default_nettype wire

// File: source/store_decode.sv
`default_nettype none

module store_decode
    import dcache_pkg::*;
(
    input  cpu_req_t req,
    output store_t   store
);

    always_comb begin
        store.strb = 4'b1111;
        store.data = req.wdata;
        case (req.op)
            op_stb: begin
                store.strb = strb_t'(4'b0001 << req.addr[1:0]);
                store.data = word_t'(req.wdata[7:0]) << {req.addr[1:0], 3'b000};
            end
            op_sth: begin
                case (req.addr[1:0])
                    2'b00: begin
                        store.strb = 4'b0011;
                        store.data = {16'h0, req.wdata[15:0]};
                    end
                    2'b10: begin
                        store.strb = 4'b1100;
                        store.data = {req.wdata[15:0], 16'h0};
                    end
                    default: begin
                        // misaligned, full word goes out as is
                        store.strb = 4'b1111;
                        store.data = req.wdata;
                    end
                endcase
            end
            default: begin
                store.strb = 4'b1111;
                store.data = req.wdata;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // geometry
    localparam int ways           = 2;
    localparam int sets           = 16;
    localparam int words_per_line = 4;

    localparam logic [7:0] burst_len_line   = 8'd3; // four beats
    localparam logic [7:0] burst_len_single = 8'd0;

    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  word_t;
    typedef logic [3:0]   strb_t;
    typedef logic [23:0]  tag_t;    // addr[31:8]
    typedef logic [3:0]   index_t;  // addr[7:4]
    typedef logic [1:0]   offset_t; // addr[3:2]
    typedef logic [127:0] line_t;

    // load/store access codes
    typedef enum logic [2:0] {
        op_ldw  = 3'd0,
        op_stw  = 3'd1,
        op_ldb  = 3'd2,
        op_ldh  = 3'd3,
        op_ldbu = 3'd4,
        op_ldhu = 3'd5,
        op_stb  = 3'd6,
        op_sth  = 3'd7
    } mem_op_t;

    typedef struct packed {
        addr_t   addr;
        word_t   wdata;
        mem_op_t op;
        logic    is_write;
        logic    uncache;
    } cpu_req_t;

    typedef struct packed {
        strb_t strb;
        word_t data;
    } store_t;

endpackage

`default_nettype wire
